// ==== all.f ====
rtl/pc_sel_pkg.sv
rtl/pc_ft_pkg.sv
rtl/pc_target_select.sv
rtl/tmr_pc_voter.sv
rtl/breakage_monitor.sv
rtl/pc_ft_top.sv
testbench/pc_ft_tb.sv

// ==== Bender.yml ====
package:
  name: pc_ft

sources:
  - rtl/pc_sel_pkg.sv
  - rtl/pc_ft_pkg.sv
  - rtl/pc_target_select.sv
  - rtl/tmr_pc_voter.sv
  - rtl/breakage_monitor.sv
  - rtl/pc_ft_top.sv
  - target: test
    files:
      - testbench/pc_ft_tb.sv

// ==== testbench/pc_ft_tb.sv ====
// Random self-checking testbench for pc_ft_top; the model tracks breakage counters only from a reset
`timescale 1ns/10ps

module pc_ft_tb;

        localparam int RESET_CYCLES   = 16;
        localparam int RANDOM_CYCLES  = 1600;
        localparam int SINGLE_ROUNDS  = 30;
        localparam int SCATTER_ROUNDS = 30;
        localparam int ROUND_LEN      = 6;
        localparam int BURST_CYCLES   = 12;
        localparam int TEST_CYCLES    = 3 * RESET_CYCLES + RANDOM_CYCLES + BURST_CYCLES + 40
                                      + (SINGLE_ROUNDS + SCATTER_ROUNDS) * ROUND_LEN;
        // Half again the expected run length before giving up
        localparam int CYCLE_LIMIT    = TEST_CYCLES * 3 / 2;
        localparam int CNT_MAX        = 2 ** pc_ft_pkg::CNT_W - 1;

        logic clk = 1'b0;
        logic rst_n_i;
        pc_sel_pkg::pc_mux_e     [2:0]                          pc_mux;
        pc_sel_pkg::exc_pc_mux_e [2:0]                          exc_pc_mux;
        logic [2:0][pc_sel_pkg::VEC_W-1:0]                      m_exc_vec;
        logic [2:0][pc_sel_pkg::TRAP_BASE_W-1:0]                m_trap_base;
        logic [2:0][31:0]                                       boot_addr;
        logic [2:0][31:0]                                       dm_halt_addr;
        logic [2:0][31:0]                                       dm_exception_addr;
        logic [2:0][31:0]                                       jump_target_id;
        logic [2:0][31:0]                                       jump_target_ex;
        logic [2:0][31:0]                                       mepc;
        logic [2:0][31:0]                                       depc;
        logic [2:0][31:0]                                       pc_id;
        logic [2:0]                                             pc_set;
        logic [2:0]                                             set_broken;
        logic [31:0]                                            branch_addr;
        logic                                                   csr_mtvec_init;
        logic [2:0]                                             is_broken;
        logic                                                   err_detected;
        logic                                                   err_corrected;

        // Reference state, updated just before the edge that the DUT registers on
        int         cnt_m [3];
        logic [2:0] broken_m;
        int         cycles = 0;

        pc_ft_top DUT (
                .clk (clk), .rst_n_i (rst_n_i),
                .pc_mux_i (pc_mux), .exc_pc_mux_i (exc_pc_mux), .m_exc_vec_i (m_exc_vec),
                .m_trap_base_i (m_trap_base), .boot_addr_i (boot_addr),
                .dm_halt_addr_i (dm_halt_addr), .dm_exception_addr_i (dm_exception_addr),
                .jump_target_id_i (jump_target_id), .jump_target_ex_i (jump_target_ex),
                .mepc_i (mepc), .depc_i (depc), .pc_id_i (pc_id), .pc_set_i (pc_set),
                .set_broken_i (set_broken), .branch_addr_o (branch_addr),
                .csr_mtvec_init_o (csr_mtvec_init), .is_broken_o (is_broken),
                .err_detected_o (err_detected), .err_corrected_o (err_corrected)
        );

        always #10 clk = ~clk;

        always @(posedge clk) begin
                cycles <= cycles + 1;
                if (cycles >= CYCLE_LIMIT) begin
                        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
                        $display("Errors found");
                        $fatal(1, "timeout");
                end
        end

        task automatic check_value(input string name, input logic [31:0] act,
                                   input logic [31:0] exp);
                if (act !== exp) begin
                        $display("error %s: got %h, expected %h", name, act, exp);
                        $display("Errors found");
                        $fatal(1, "mismatch");
                end
        endtask

        //////////////////////////////////////////////////
        // Reference model
        //////////////////////////////////////////////////

        function automatic logic [31:0] expected_target(input int k);
                logic [31:0] trap;
                trap = {m_trap_base[k], 8'h00};
                case (pc_mux[k])
                        pc_sel_pkg::PC_BOOT: begin
                                return (boot_addr[k] & 32'hFFFF_FF00)
                                       | 32'(pc_sel_pkg::BOOT_OFFSET);
                        end
                        pc_sel_pkg::PC_FENCEI: return pc_id[k] + 32'd4;
                        pc_sel_pkg::PC_JUMP:   return jump_target_id[k];
                        pc_sel_pkg::PC_BRANCH: return jump_target_ex[k];
                        pc_sel_pkg::PC_MRET:   return mepc[k];
                        pc_sel_pkg::PC_DRET:   return depc[k];
                        pc_sel_pkg::PC_EXCEPTION: begin
                                // Vector slots are 4 bytes apart above the trap base
                                if (exc_pc_mux[k] == pc_sel_pkg::EXC_PC_EXCEPTION) return trap;
                                if (exc_pc_mux[k] == pc_sel_pkg::EXC_PC_IRQ) begin
                                        return trap | (32'(m_exc_vec[k]) << 2);
                                end
                                if (exc_pc_mux[k] == pc_sel_pkg::EXC_PC_DBD) return dm_halt_addr[k];
                                return dm_exception_addr[k];
                        end
                        default: return pc_id[k];
                endcase
        endfunction

        task automatic vote(input logic [31:0] v [3], input logic [2:0] brk,
                            output logic [31:0] voted, output logic [2:0] berr,
                            output logic corr);
                int healthy[$];
                berr = 3'b000;
                for (int k = 0; k < 3; k++) if (!brk[k]) healthy.push_back(k);
                if (healthy.size() == 3) begin
                        // Each bit takes the value held by at least two copies
                        for (int b = 0; b < 32; b++) begin
                                voted[b] = $countones({v[0][b], v[1][b], v[2][b]}) > 1;
                        end
                        for (int k = 0; k < 3; k++) berr[k] = (v[k] != voted);
                end else if (healthy.size() == 2) begin
                        voted = v[healthy[0]];
                        if (v[healthy[0]] != v[healthy[1]]) begin
                                berr[healthy[0]] = 1'b1;
                                berr[healthy[1]] = 1'b1;
                        end
                end else begin
                        voted = (healthy.size() == 1) ? v[healthy[0]] : v[0];
                end
                corr = (healthy.size() == 3) && ($countones(berr) == 1);
        endtask

        task automatic clear_model();
                for (int k = 0; k < 3; k++) cnt_m[k] = 0;
                broken_m = 3'b000;
        endtask

        // Checks mid-cycle, then advances the model and moves to the next drive point
        task automatic run_cycle();
                logic [31:0] addr_v [3];
                logic [31:0] init_v [3];
                logic [31:0] exp_addr;
                logic [31:0] exp_init;
                logic [2:0]  berr_a;
                logic [2:0]  berr_i;
                logic        corr_a;
                logic        corr_i;
                @(negedge clk);
                for (int k = 0; k < 3; k++) begin
                        addr_v[k] = expected_target(k);
                        init_v[k] = (pc_set[k] && pc_mux[k] == pc_sel_pkg::PC_BOOT) ? 32'd1 : 32'd0;
                end
                vote(addr_v, broken_m, exp_addr, berr_a, corr_a);
                vote(init_v, broken_m, exp_init, berr_i, corr_i);
                check_value("branch_addr_o", branch_addr, exp_addr);
                check_value("csr_mtvec_init_o", csr_mtvec_init, exp_init);
                check_value("is_broken_o", is_broken, broken_m);
                check_value("err_detected_o", err_detected, |(berr_a | berr_i));
                check_value("err_corrected_o", err_corrected, corr_a | corr_i);
                for (int k = 0; k < 3; k++) begin
                        if (berr_a[k] || berr_i[k]) begin
                                cnt_m[k] = (cnt_m[k] + pc_ft_pkg::CNT_INC > CNT_MAX)
                                           ? CNT_MAX : cnt_m[k] + pc_ft_pkg::CNT_INC;
                        end else begin
                                cnt_m[k] = (cnt_m[k] > pc_ft_pkg::CNT_DEC)
                                           ? cnt_m[k] - pc_ft_pkg::CNT_DEC : 0;
                        end
                        if (set_broken[k] || cnt_m[k] >= pc_ft_pkg::BREAK_THRESHOLD) begin
                                broken_m[k] = 1'b1;
                        end
                end
                @(posedge clk);
                #2;
        endtask

        //////////////////////////////////////////////////
        // Stimulus
        //////////////////////////////////////////////////

        // One random input set copied to all three replicas
        task automatic random_inputs();
                logic [3:0]  code;
                logic [1:0]  exc;
                logic [31:0] f [10];
                logic        set;
                code = $urandom_range(15, 0);
                exc  = $urandom_range(3, 0);
                set  = $urandom_range(1, 0);
                for (int i = 0; i < 10; i++) f[i] = $urandom;
                for (int k = 0; k < 3; k++) begin
                        pc_mux[k]            = pc_sel_pkg::pc_mux_e'(code);
                        exc_pc_mux[k]        = pc_sel_pkg::exc_pc_mux_e'(exc);
                        m_exc_vec[k]         = f[0][pc_sel_pkg::VEC_W-1:0];
                        m_trap_base[k]       = f[1][pc_sel_pkg::TRAP_BASE_W-1:0];
                        boot_addr[k]         = f[2];
                        dm_halt_addr[k]      = f[3];
                        dm_exception_addr[k] = f[4];
                        jump_target_id[k]    = f[5];
                        jump_target_ex[k]    = f[6];
                        mepc[k]              = f[7];
                        depc[k]              = f[8];
                        pc_id[k]             = f[9];
                        pc_set[k]            = set;
                end
                set_broken = 3'b000;
        endtask

        // Forces a jump so that a flipped target copy always reaches the address voter
        task automatic corrupt_jump(input int k);
                for (int i = 0; i < 3; i++) pc_mux[i] = pc_sel_pkg::PC_JUMP;
                jump_target_id[k] = jump_target_id[k] ^ ($urandom | 32'h1);
        endtask

        // Boot with one replica missing its pc_set, so only the mtvec-init vote differs
        task automatic corrupt_init(input int k);
                for (int i = 0; i < 3; i++) begin
                        pc_mux[i] = pc_sel_pkg::PC_BOOT;
                        pc_set[i] = (i != k);
                end
        endtask

        task automatic apply_reset();
                rst_n_i = 1'b0;
                random_inputs();
                clear_model();
                repeat (RESET_CYCLES) @(posedge clk);
                #2;
                rst_n_i = 1'b1;
        endtask

        initial begin
                int r;
                int q;
                void'($urandom(53));
                apply_reset();
                repeat (RANDOM_CYCLES) begin
                        random_inputs();
                        run_cycle();
                end
                // Isolated faults on either vote, each followed by enough clean cycles to drain
                repeat (SINGLE_ROUNDS) begin
                        random_inputs();
                        r = $urandom_range(2, 0);
                        if ($urandom_range(1, 0)) begin
                                corrupt_init(r);
                        end else begin
                                corrupt_jump(r);
                        end
                        run_cycle();
                        repeat ($urandom_range(ROUND_LEN - 1, 3)) begin
                                random_inputs();
                                run_cycle();
                        end
                end
                // Burst of three errors retires the replica on the following cycle
                r = $urandom_range(2, 0);
                repeat (3) begin
                        random_inputs();
                        corrupt_jump(r);
                        run_cycle();
                end
                check_value("is_broken_o", is_broken[r], 1'b1);
                repeat (BURST_CYCLES) begin
                        random_inputs();
                        corrupt_jump(r);
                        run_cycle();
                end
                apply_reset();
                q = $urandom_range(2, 0);
                random_inputs();
                set_broken[q] = 1'b1;
                run_cycle();
                check_value("is_broken_o", is_broken, 3'b001 << q);
                // Two healthy copies left, they can only detect
                r = (q + $urandom_range(2, 1)) % 3;
                repeat (2) begin
                        random_inputs();
                        corrupt_jump(r);
                        run_cycle();
                end
                repeat (8) begin
                        random_inputs();
                        run_cycle();
                end
                repeat (SCATTER_ROUNDS) begin
                        random_inputs();
                        corrupt_jump($urandom_range(2, 0));
                        run_cycle();
                        repeat ($urandom_range(ROUND_LEN - 1, 3)) begin
                                random_inputs();
                                run_cycle();
                        end
                end
                check_value("is_broken_o", is_broken, 3'b001 << q);
                apply_reset();
                check_value("is_broken_o", is_broken, 3'b000);
                repeat (20) begin
                        random_inputs();
                        run_cycle();
                end
                $display("No errors");
                $finish;
        end

endmodule

// ==== rtl/pc_ft_top.sv ====
// Triplicated next-PC selector; every input must arrive as three copies, outputs are combinational
`timescale 1ns/10ps

module pc_ft_top (
        input  logic                                                    clk,
        input  logic                                                    rst_n_i,
        input  pc_sel_pkg::pc_mux_e     [pc_ft_pkg::N_REPLICA-1:0]      pc_mux_i,
        input  pc_sel_pkg::exc_pc_mux_e [pc_ft_pkg::N_REPLICA-1:0]      exc_pc_mux_i,
        input  logic [pc_ft_pkg::N_REPLICA-1:0][pc_sel_pkg::VEC_W-1:0]  m_exc_vec_i,
        input  logic [pc_ft_pkg::N_REPLICA-1:0][pc_sel_pkg::TRAP_BASE_W-1:0] m_trap_base_i,
        input  logic [pc_ft_pkg::N_REPLICA-1:0][pc_sel_pkg::ADDR_W-1:0] boot_addr_i,
        input  logic [pc_ft_pkg::N_REPLICA-1:0][pc_sel_pkg::ADDR_W-1:0] dm_halt_addr_i,
        input  logic [pc_ft_pkg::N_REPLICA-1:0][pc_sel_pkg::ADDR_W-1:0] dm_exception_addr_i,
        input  logic [pc_ft_pkg::N_REPLICA-1:0][pc_sel_pkg::ADDR_W-1:0] jump_target_id_i,
        input  logic [pc_ft_pkg::N_REPLICA-1:0][pc_sel_pkg::ADDR_W-1:0] jump_target_ex_i,
        input  logic [pc_ft_pkg::N_REPLICA-1:0][pc_sel_pkg::ADDR_W-1:0] mepc_i,
        input  logic [pc_ft_pkg::N_REPLICA-1:0][pc_sel_pkg::ADDR_W-1:0] depc_i,
        input  logic [pc_ft_pkg::N_REPLICA-1:0][pc_sel_pkg::ADDR_W-1:0] pc_id_i,
        input  logic [pc_ft_pkg::N_REPLICA-1:0]                         pc_set_i,
        input  logic [pc_ft_pkg::N_REPLICA-1:0]                         set_broken_i,
        output logic [pc_sel_pkg::ADDR_W-1:0]                           branch_addr_o,
        output logic                                                    csr_mtvec_init_o,
        output logic [pc_ft_pkg::N_REPLICA-1:0]                         is_broken_o,
        output logic                                                    err_detected_o,
        output logic                                                    err_corrected_o
);

        logic [pc_ft_pkg::N_REPLICA-1:0][pc_sel_pkg::ADDR_W-1:0] addr_to_vote;
        logic [pc_ft_pkg::N_REPLICA-1:0]                         init_to_vote;
        logic [pc_ft_pkg::N_REPLICA-1:0]                         addr_block_err;
        logic [pc_ft_pkg::N_REPLICA-1:0]                         init_block_err;
        logic [pc_ft_pkg::N_REPLICA-1:0]                         replica_err;
        logic [1:0]                                              detected;
        logic [1:0]                                              corrected;

        //////////////////////////////////////////////////
        // Replicas, each on its own input copy
        //////////////////////////////////////////////////

        for (genvar k = 0; k < pc_ft_pkg::N_REPLICA; k++) begin : g_replica
                pc_target_select u_sel (
                        .pc_mux_i            (pc_mux_i[k]),
                        .exc_pc_mux_i        (exc_pc_mux_i[k]),
                        .m_exc_vec_i         (m_exc_vec_i[k]),
                        .m_trap_base_i       (m_trap_base_i[k]),
                        .boot_addr_i         (boot_addr_i[k]),
                        .dm_halt_addr_i      (dm_halt_addr_i[k]),
                        .dm_exception_addr_i (dm_exception_addr_i[k]),
                        .jump_target_id_i    (jump_target_id_i[k]),
                        .jump_target_ex_i    (jump_target_ex_i[k]),
                        .mepc_i              (mepc_i[k]),
                        .depc_i              (depc_i[k]),
                        .pc_id_i             (pc_id_i[k]),
                        .pc_set_i            (pc_set_i[k]),
                        .branch_addr_o       (addr_to_vote[k]),
                        .csr_mtvec_init_o    (init_to_vote[k])
                );
        end

        //////////////////////////////////////////////////
        // Voting
        //////////////////////////////////////////////////

        tmr_pc_voter #(.WIDTH(pc_sel_pkg::ADDR_W)) u_addr_voter (
                .to_vote_i       (addr_to_vote),
                .broken_i        (is_broken_o),
                .voted_o         (branch_addr_o),
                .block_err_o     (addr_block_err),
                .err_detected_o  (detected[0]),
                .err_corrected_o (corrected[0])
        );

        tmr_pc_voter #(.WIDTH(1)) u_init_voter (
                .to_vote_i       (init_to_vote),
                .broken_i        (is_broken_o),
                .voted_o         (csr_mtvec_init_o),
                .block_err_o     (init_block_err),
                .err_detected_o  (detected[1]),
                .err_corrected_o (corrected[1])
        );

        // A replica is faulty if it lost either vote
        assign replica_err     = addr_block_err | init_block_err;
        assign err_detected_o  = |detected;
        assign err_corrected_o = |corrected;

        // Monitors feed the voter masks from the previous cycles
        for (genvar m = 0; m < pc_ft_pkg::N_REPLICA; m++) begin : g_monitor
                breakage_monitor u_mon (
                        .clk          (clk),
                        .rst_n_i      (rst_n_i),
                        .err_i        (replica_err[m]),
                        .set_broken_i (set_broken_i[m]),
                        .is_broken_o  (is_broken_o[m])
                );
        end

endmodule

// ==== rtl/breakage_monitor.sv ====
// Per-replica error counter, saturating at 0 and all ones; the broken flag only clears on reset
`timescale 1ns/10ps

module breakage_monitor (
        input  logic clk,
        input  logic rst_n_i,
        input  logic err_i,
        input  logic set_broken_i,
        output logic is_broken_o
);

        logic [pc_ft_pkg::CNT_W-1:0] cnt_q;
        logic [pc_ft_pkg::CNT_W-1:0] cnt_d;
        logic [pc_ft_pkg::CNT_W:0]   cnt_sum;
        logic                        broken_q;

        // Extra carry bit catches overflow of the increment
        assign cnt_sum = {1'b0, cnt_q} + {1'b0, pc_ft_pkg::CNT_INC};

        always_comb begin
                if (err_i) begin
                        cnt_d = cnt_sum[pc_ft_pkg::CNT_W] ? '1 : cnt_sum[pc_ft_pkg::CNT_W-1:0];
                end else if (cnt_q < pc_ft_pkg::CNT_DEC) begin
                        cnt_d = '0;
                end else begin
                        cnt_d = cnt_q - pc_ft_pkg::CNT_DEC;
                end
        end

        always_ff @(posedge clk or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        cnt_q    <= '0;
                        broken_q <= 1'b0;
                end else begin
                        cnt_q <= cnt_d;
                        // Threshold is checked on the updated count
                        if (set_broken_i || (cnt_d >= pc_ft_pkg::BREAK_THRESHOLD)) begin
                                broken_q <= 1'b1;
                        end
                end
        end

        assign is_broken_o = broken_q;

endmodule

// ==== rtl/tmr_pc_voter.sv ====
// Combinational three-way voter; a retired replica is skipped and with two retired no error is reported
`timescale 1ns/10ps

module tmr_pc_voter #(
        parameter int unsigned WIDTH = 32
) (
        input  logic [pc_ft_pkg::N_REPLICA-1:0][WIDTH-1:0] to_vote_i,
        input  logic [pc_ft_pkg::N_REPLICA-1:0]            broken_i,
        output logic [WIDTH-1:0]                           voted_o,
        output logic [pc_ft_pkg::N_REPLICA-1:0]            block_err_o,
        output logic                                       err_detected_o,
        output logic                                       err_corrected_o
);

        logic [WIDTH-1:0] majority;
        logic             mis_01;
        logic             mis_02;
        logic             mis_12;

        //////////////////////////////////////////////////
        // Raw comparisons
        //////////////////////////////////////////////////

        assign majority = (to_vote_i[0] & to_vote_i[1])
                        | (to_vote_i[0] & to_vote_i[2])
                        | (to_vote_i[1] & to_vote_i[2]);

        // Pairwise disagreement, used once a replica is retired
        assign mis_01 = (to_vote_i[0] != to_vote_i[1]);
        assign mis_02 = (to_vote_i[0] != to_vote_i[2]);
        assign mis_12 = (to_vote_i[1] != to_vote_i[2]);

        //////////////////////////////////////////////////
        // Selection by broken mask
        //////////////////////////////////////////////////

        always_comb begin
                case (broken_i)
                        3'b000: begin
                                voted_o        = majority;
                                block_err_o[0] = (to_vote_i[0] != majority);
                                block_err_o[1] = (to_vote_i[1] != majority);
                                block_err_o[2] = (to_vote_i[2] != majority);
                        end
                        // One retired: the two healthy copies can only detect
                        3'b001: begin
                                voted_o     = to_vote_i[1];
                                block_err_o = {mis_12, mis_12, 1'b0};
                        end
                        3'b010: begin
                                voted_o     = to_vote_i[0];
                                block_err_o = {mis_02, 1'b0, mis_02};
                        end
                        3'b100: begin
                                voted_o     = to_vote_i[0];
                                block_err_o = {1'b0, mis_01, mis_01};
                        end
                        // Two or more retired, nothing left to compare
                        3'b011: begin
                                voted_o     = to_vote_i[2];
                                block_err_o = 3'b000;
                        end
                        3'b101: begin
                                voted_o     = to_vote_i[1];
                                block_err_o = 3'b000;
                        end
                        default: begin
                                voted_o     = to_vote_i[0];
                                block_err_o = 3'b000;
                        end
                endcase
        end

        assign err_detected_o = |block_err_o;

        // Only a single outvoted copy with all three healthy is a real correction
        assign err_corrected_o = (broken_i == 3'b000) && $onehot(block_err_o);

endmodule

// ==== rtl/pc_target_select.sv ====
// Purely combinational next-PC mux for one replica; machine trap base only, unused source codes return pc_id
`timescale 1ns/10ps

module pc_target_select (
        input  pc_sel_pkg::pc_mux_e                    pc_mux_i,
        input  pc_sel_pkg::exc_pc_mux_e                exc_pc_mux_i,
        input  logic [pc_sel_pkg::VEC_W-1:0]           m_exc_vec_i,
        input  logic [pc_sel_pkg::TRAP_BASE_W-1:0]     m_trap_base_i,
        input  logic [pc_sel_pkg::ADDR_W-1:0]          boot_addr_i,
        input  logic [pc_sel_pkg::ADDR_W-1:0]          dm_halt_addr_i,
        input  logic [pc_sel_pkg::ADDR_W-1:0]          dm_exception_addr_i,
        input  logic [pc_sel_pkg::ADDR_W-1:0]          jump_target_id_i,
        input  logic [pc_sel_pkg::ADDR_W-1:0]          jump_target_ex_i,
        input  logic [pc_sel_pkg::ADDR_W-1:0]          mepc_i,
        input  logic [pc_sel_pkg::ADDR_W-1:0]          depc_i,
        input  logic [pc_sel_pkg::ADDR_W-1:0]          pc_id_i,
        input  logic                                   pc_set_i,
        output logic [pc_sel_pkg::ADDR_W-1:0]          branch_addr_o,
        output logic                                   csr_mtvec_init_o
);

        logic [pc_sel_pkg::ADDR_W-1:0] exc_addr;

        // Trap vector table entries are word aligned
        always_comb begin
                case (exc_pc_mux_i)
                        pc_sel_pkg::EXC_PC_EXCEPTION: begin
                                exc_addr = {m_trap_base_i, 8'h00};
                        end
                        pc_sel_pkg::EXC_PC_IRQ: begin
                                // One slot per interrupt index
                                exc_addr = {m_trap_base_i, 1'b0, m_exc_vec_i, 2'b00};
                        end
                        pc_sel_pkg::EXC_PC_DBD: begin
                                exc_addr = dm_halt_addr_i;
                        end
                        default: begin
                                exc_addr = dm_exception_addr_i;
                        end
                endcase
        end

        always_comb begin
                case (pc_mux_i)
                        pc_sel_pkg::PC_BOOT: begin
                                branch_addr_o = {boot_addr_i[pc_sel_pkg::ADDR_W-1:8],
                                                 pc_sel_pkg::BOOT_OFFSET};
                        end
                        pc_sel_pkg::PC_FENCEI: begin
                                // Restart right after the fence.i
                                branch_addr_o = pc_id_i + 32'd4;
                        end
                        pc_sel_pkg::PC_JUMP:      branch_addr_o = jump_target_id_i;
                        pc_sel_pkg::PC_BRANCH:    branch_addr_o = jump_target_ex_i;
                        pc_sel_pkg::PC_EXCEPTION: branch_addr_o = exc_addr;
                        pc_sel_pkg::PC_MRET:      branch_addr_o = mepc_i;
                        pc_sel_pkg::PC_DRET:      branch_addr_o = depc_i;
                        default: begin
                                branch_addr_o = pc_id_i;
                        end
                endcase
        end

        // mtvec is loaded from the boot address when booting
        assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == pc_sel_pkg::PC_BOOT);

endmodule

// ==== rtl/pc_ft_pkg.sv ====
// Redundancy constants for exactly three replicas; CNT_W must hold BREAK_THRESHOLD and CNT_INC
package pc_ft_pkg;

        //////////////////////////////////////////////////
        // Replication
        //////////////////////////////////////////////////

        // The voter logic is written for three copies only
        localparam int unsigned N_REPLICA = 3;

        //////////////////////////////////////////////////
        // Breakage counter
        //////////////////////////////////////////////////

        // Counter width, saturates at its all-ones value
        localparam int unsigned CNT_W = 4;

        // Errors weigh more than clean cycles, so bursts retire a replica
        localparam logic [CNT_W-1:0] CNT_INC = 4'd3;
        localparam logic [CNT_W-1:0] CNT_DEC = 4'd1;

        // Replica counts as broken at or above this value
        localparam logic [CNT_W-1:0] BREAK_THRESHOLD = 4'd8;

endpackage

// ==== rtl/pc_sel_pkg.sv ====
// Address widths and PC source codes for a machine-mode-only core; user mode and hardware loops are not covered
package pc_sel_pkg;

        //////////////////////////////////////////////////
        // Address widths
        //////////////////////////////////////////////////

        // Every PC source is a full byte address
        localparam int unsigned ADDR_W      = 32;

        // mtvec base field, upper bits of the trap vector table
        localparam int unsigned TRAP_BASE_W = 24;

        // Interrupt index inside the vector table
        localparam int unsigned VEC_W       = 5;

        // Boot entry sits at this offset inside the boot page
        localparam logic [7:0]  BOOT_OFFSET = 8'h80;

        //////////////////////////////////////////////////
        // Source encodings
        //////////////////////////////////////////////////

        // Next-PC source, as driven by the controller
        // Code 6 and codes 8 to 15 are unused and fall back to pc_id
        typedef enum logic [3:0] {
                PC_BOOT      = 4'd0,
                PC_FENCEI    = 4'd1,
                PC_JUMP      = 4'd2,
                PC_BRANCH    = 4'd3,
                PC_EXCEPTION = 4'd4,
                PC_MRET      = 4'd5,
                PC_DRET      = 4'd7
        } pc_mux_e;

        // Address used when pc_mux selects PC_EXCEPTION
        typedef enum logic [1:0] {
                EXC_PC_EXCEPTION = 2'd0,
                EXC_PC_IRQ       = 2'd1,
                EXC_PC_DBD       = 2'd2,
                EXC_PC_DBE       = 2'd3
        } exc_pc_mux_e;

endpackage
